/* Bender.yml */
package:
  name: pathCrypt

sources:
  - verilog/oramGeometryPkg.sv
  - verilog/cipherPkg.sv
  - verilog/burstStreamIf.sv
  - verilog/syncFifo.sv
  - verilog/bucketIngress.sv
  - verilog/keystreamGen.sv
  - verilog/bucketEgress.sv
  - verilog/pathCrypt.sv
  - target: test
    files:
      - verif/pathCryptTb.sv

/* pathCrypt.f */
verilog/oramGeometryPkg.sv
verilog/cipherPkg.sv
verilog/burstStreamIf.sv
verilog/syncFifo.sv
verilog/bucketIngress.sv
verilog/keystreamGen.sv
verilog/bucketEgress.sv
verilog/pathCrypt.sv
verif/pathCryptTb.sv

/* verif/pathCryptTb.sv */
// Directed testbench for the path encryption layer.
// Drives read and write paths against a reference model, with and without back-pressure.
`timescale 1ns/100ps

module pathCryptTb;
    import cipherPkg::*;
    import oramGeometryPkg::*;

    localparam int CycleLimit = 3000;
    localparam int TotalPaths = 5;

    logic  Clock = 1'b0;
    logic  reset;
    logic  dramInitDone;
    burstT migIn;
    logic  migInValid;
    burstT migOut;
    maskT  migOutMask;
    logic  migOutValid;
    logic  migOutReady = 1'b1;
    burstT backendRData;
    logic  backendRValid;
    logic  backendRReady = 1'b1;
    burstT backendWData;
    maskT  backendWMask;
    logic  backendWValid;
    logic  backendWReady;

    // Captured outputs, in order
    burstT readQ[$];
    burstT writeQ[$];
    maskT  writeMaskQ[$];
    int    dirQ[$];
    int    readValidCycles = 0;
    int    writeValidCycles = 0;
    int    cycles = 0;
    logic  jitterReady = 1'b0;

    // Current path stimulus and model results
    burstT srcPath [PathBursts];
    maskT  maskPath [PathBursts];
    burstT expPath [PathBursts];
    burstT plainSaved [PathBursts];
    burstT cipherSaved [PathBursts];

    pathCrypt uut (.*);

    always #2 Clock = ~Clock;

    // Output readiness is random only during the back-pressure test
    always @(negedge Clock) begin
        backendRReady = jitterReady ? (($urandom % 2) != 0) : 1'b1;
        migOutReady   = jitterReady ? (($urandom % 2) != 0) : 1'b1;
    end

    always @(posedge Clock) begin
        if (backendRValid) readValidCycles++;
        if (migOutValid) writeValidCycles++;
        if (backendRValid && backendRReady) begin
            readQ.push_back(backendRData);
            dirQ.push_back(0);
        end
        if (migOutValid && migOutReady) begin
            writeQ.push_back(migOut);
            writeMaskQ.push_back(migOutMask);
            dirQ.push_back(1);
        end
    end

    always @(posedge Clock) begin
        cycles++;
        if (cycles >= CycleLimit) begin
            $display("Timeout: the run did not finish within %0d cycles", CycleLimit);
            $display("SOME TESTS FAILED");
            $fatal(1, "Timeout");
        end
    end

    // --------------------------------------------------
    // Reference model
    // --------------------------------------------------

    // Counter word through three keyed rounds
    function automatic laneT laneKey(input ivT bucketIv, input int k, input int l);
        laneT w;
        w = laneT'(bucketIv) + laneT'(k * Lanes + l);
        for (int s = 1; s <= MixStages; s++) begin
            w = w ^ CipherKey;
            w = {w[24:0], w[31:25]};
            w = w + laneT'(s);
        end
        return w;
    endfunction

    function automatic burstT cryptBurst(input burstT in, input ivT bucketIv, input int k);
        burstT ks;
        burstT res;
        for (int l = 0; l < Lanes; l++) begin
            ks[l*LaneWidth +: LaneWidth] = laneKey(bucketIv, k, l);
        end
        res = in ^ ks;
        // Header keeps its IV field
        if (k == 0) res[IvWidth-1:0] = in[IvWidth-1:0];
        return res;
    endfunction

    function automatic void modelPath();
        int k;
        ivT bucketIv;
        for (int i = 0; i < PathBursts; i++) begin
            k          = i % BucketBursts;
            bucketIv   = srcPath[i - k][IvWidth-1:0];
            expPath[i] = cryptBurst(srcPath[i], bucketIv, k);
        end
    endfunction

    function automatic void randomPath();
        for (int i = 0; i < PathBursts; i++) begin
            srcPath[i]  = {$urandom, $urandom};
            maskPath[i] = maskT'($urandom);
        end
    endfunction

    // --------------------------------------------------
    // Checks
    // --------------------------------------------------
    task automatic failRun();
        $display("SOME TESTS FAILED");
        $fatal(1, "Check failed");
    endtask

    task automatic checkValue(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
        assert (got === exp) else begin
            $display("Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            failRun();
        end
    endtask

    task automatic checkCondition(input bit cond, input string what);
        assert (cond) else begin
            $display("At %0t ns: %s", $time, what);
            failRun();
        end
    endtask

    // --------------------------------------------------
    // Drivers and tests
    // --------------------------------------------------
    task automatic driveMemPath();
        for (int i = 0; i < PathBursts; i++) begin
            @(negedge Clock);
            migIn      = srcPath[i];
            migInValid = 1'b1;
        end
        @(negedge Clock);
        migInValid = 1'b0;
    endtask

    task automatic driveBackendPath();
        for (int i = 0; i < PathBursts; i++) begin
            @(negedge Clock);
            backendWData  = srcPath[i];
            backendWMask  = maskPath[i];
            backendWValid = 1'b1;
            @(posedge Clock);
            while (!backendWReady) @(posedge Clock);
        end
        @(negedge Clock);
        backendWValid = 1'b0;
    endtask

    task automatic testIdleBeforeInit();
        for (int i = 0; i < 20; i++) begin
            @(negedge Clock);
            migIn      = {$urandom, $urandom};
            migInValid = i[0];
            @(posedge Clock);
            checkValue("migOutValid", migOutValid, 0);
            checkValue("backendRValid", backendRValid, 0);
            checkValue("backendWReady", backendWReady, 0);
        end
        @(negedge Clock);
        migInValid   = 1'b0;
        dramInitDone = 1'b1;
    endtask

    task automatic testReadPath(input string label);
        int writeBefore;
        writeBefore = writeValidCycles;
        readQ.delete();
        driveMemPath();
        while (readQ.size() < PathBursts) @(negedge Clock);
        for (int i = 0; i < PathBursts; i++) begin
            checkValue($sformatf("backendRData[%0d]", i), readQ[i], expPath[i]);
        end
        checkCondition(writeValidCycles == writeBefore,
                       {"migOutValid went high during read path ", label});
    endtask

    task automatic testWritePath(input string label);
        int readBefore;
        readBefore = readValidCycles;
        writeQ.delete();
        writeMaskQ.delete();
        driveBackendPath();
        while (writeQ.size() < PathBursts) @(negedge Clock);
        for (int i = 0; i < PathBursts; i++) begin
            checkValue($sformatf("migOut[%0d]", i), writeQ[i], expPath[i]);
            checkValue($sformatf("migOutMask[%0d]", i), writeMaskQ[i], maskPath[i]);
        end
        checkCondition(readValidCycles == readBefore,
                       {"backendRValid went high during write path ", label});
    endtask

    task automatic checkAlternation();
        repeat (20) @(negedge Clock);
        checkCondition(dirQ.size() == TotalPaths * PathBursts,
                       "output burst count does not match the paths driven");
        for (int i = 0; i < dirQ.size(); i++) begin
            checkValue($sformatf("direction of output %0d", i), dirQ[i],
                       (i / PathBursts) % 2);
        end
    endtask

    initial begin
        void'($urandom(24919));
        reset         = 1'b1;
        dramInitDone  = 1'b0;
        migIn         = '0;
        migInValid    = 1'b0;
        backendWData  = '0;
        backendWMask  = '0;
        backendWValid = 1'b0;
        repeat (8) @(negedge Clock);
        reset = 1'b0;

        testIdleBeforeInit();

        randomPath();
        modelPath();
        testReadPath("plain");

        randomPath();
        modelPath();
        plainSaved = srcPath;
        testWritePath("plain");
        cipherSaved = expPath;

        // Random stalls on both output ports
        jitterReady = 1'b1;
        randomPath();
        modelPath();
        testReadPath("with back-pressure");
        randomPath();
        modelPath();
        testWritePath("with back-pressure");
        jitterReady = 1'b0;

        // Ciphertext from the first write path decrypts to its plaintext
        srcPath = cipherSaved;
        expPath = plainSaved;
        testReadPath("round trip");

        checkAlternation();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

/* verilog/bucketEgress.sv */
// Output side of the layer. XORs each burst with its keystream word,
// restores header IVs and routes the result by the current path direction.
`timescale 1ns/100ps

module bucketEgress (
    input  logic              Clock,
    input  logic              reset,
    input  logic              dramInitDone,
    burstStreamIf.sink        burstIn,
    input  cipherPkg::burstT  keystream,
    input  logic              keyValid,
    output logic              keyTaken,
    output cipherPkg::burstT  migOut,
    output cipherPkg::maskT   migOutMask,
    output logic              migOutValid,
    input  logic              migOutReady,
    output cipherPkg::burstT  backendRData,
    output logic              backendRValid,
    input  logic              backendRReady
);
    import cipherPkg::*;
    import oramGeometryPkg::*;

    logic       initDone;
    pathDirT    dir;
    pathCountT  pathCount;
    logic       joinValid;
    logic       destReady;
    logic       fire;
    burstT      xorRes;
    burstT      outData;

    // --------------------------------------------------
    // Join and output rule
    // --------------------------------------------------
    assign joinValid = initDone & burstIn.valid & keyValid;
    assign destReady = (dir == PathRead) ? backendRReady : migOutReady;
    assign fire      = joinValid & destReady;

    assign burstIn.ready = fire;
    assign keyTaken      = fire;

    assign xorRes = burstIn.data ^ keystream;

    // Header IV field goes out as it came in
    assign outData = burstIn.header
                   ? {xorRes[DataWidth-1:IvWidth], burstIn.data[IvWidth-1:0]}
                   : xorRes;

    assign backendRData  = outData;
    assign backendRValid = joinValid & (dir == PathRead);
    assign migOut        = outData;
    assign migOutMask    = burstIn.mask;
    assign migOutValid   = joinValid & (dir == PathWrite);

    // --------------------------------------------------
    // Init flag, path counter and direction
    // --------------------------------------------------
    always_ff @(posedge Clock) begin
        if (reset) begin
            initDone <= 1'b0;
        end else if (dramInitDone) begin
            initDone <= 1'b1;
        end
    end

    // First path after init is a read
    always_ff @(posedge Clock) begin
        if (reset) begin
            dir       <= PathRead;
            pathCount <= '0;
        end else if (fire) begin
            if (pathCount == pathCountT'(PathBursts - 1)) begin
                pathCount <= '0;
                dir       <= (dir == PathRead) ? PathWrite : PathRead;
            end else begin
                pathCount <= pathCount + 1'b1;
            end
        end
    end

endmodule

/* verilog/bucketIngress.sv */
// Input side of the layer. Buffers memory paths, merges backend writes,
// marks bucket headers and hands each header IV to the keystream stage.
`timescale 1ns/100ps

module bucketIngress (
    input  logic              Clock,
    input  logic              reset,
    input  logic              dramInitDone,
    input  cipherPkg::burstT  migIn,
    input  logic              migInValid,
    input  cipherPkg::burstT  backendWData,
    input  cipherPkg::maskT   backendWMask,
    input  logic              backendWValid,
    output logic              backendWReady,
    output cipherPkg::ivT     iv,
    output logic              ivValid,
    input  logic              ivReady,
    burstStreamIf.source      burstOut
);
    import cipherPkg::*;
    import oramGeometryPkg::*;

    localparam int TagWidth = DataWidth + MaskWidth + 1;

    burstT                bufData;
    logic                 bufValid;
    logic                 bufReady;
    burstT                selData;
    maskT                 selMask;
    logic                 selBackend;
    logic                 isHeader;
    logic                 canTake;
    logic                 take;
    bucketCountT          bucketPos;
    logic                 dataInReady;
    logic                 ivInReady;
    logic [TagWidth-1:0]  dataOut;

    // Whole path fits, so memory input never stalls
    syncFifo #(.Width(DataWidth), .Depth(PathBursts)) pathBuffer (
        .Clock(Clock), .reset(reset),
        .inData(migIn), .inValid(migInValid & dramInitDone), .inReady(),
        .outData(bufData), .outValid(bufValid), .outReady(bufReady)
    );

    // --------------------------------------------------
    // Input selection
    // --------------------------------------------------
    assign selBackend = backendWValid;
    assign selData    = selBackend ? backendWData : bufData;
    assign selMask    = selBackend ? backendWMask : '0;
    assign isHeader   = (bucketPos == '0);

    // A header also needs room for its IV
    assign canTake       = dramInitDone & dataInReady & (ivInReady | ~isHeader);
    assign backendWReady = dramInitDone & dataInReady & ivInReady;
    assign bufReady      = ~selBackend & canTake;
    assign take          = selBackend ? backendWReady : (bufValid & canTake);

    always_ff @(posedge Clock) begin
        if (reset) begin
            bucketPos <= '0;
        end else if (take) begin
            if (bucketPos == bucketCountT'(BucketBursts - 1)) begin
                bucketPos <= '0;
            end else begin
                bucketPos <= bucketPos + 1'b1;
            end
        end
    end

    syncFifo #(.Width(IvWidth), .Depth(FifoDepth)) ivFifo (
        .Clock(Clock), .reset(reset),
        .inData(selData[IvWidth-1:0]), .inValid(take & isHeader), .inReady(ivInReady),
        .outData(iv), .outValid(ivValid), .outReady(ivReady)
    );

    // Burst travels with its mask and header flag
    syncFifo #(.Width(TagWidth), .Depth(FifoDepth)) dataFifo (
        .Clock(Clock), .reset(reset),
        .inData({isHeader, selMask, selData}), .inValid(take), .inReady(dataInReady),
        .outData(dataOut), .outValid(burstOut.valid), .outReady(burstOut.ready)
    );

    assign burstOut.data   = dataOut[DataWidth-1:0];
    assign burstOut.mask   = dataOut[DataWidth +: MaskWidth];
    assign burstOut.header = dataOut[TagWidth-1];

endmodule

/* verilog/burstStreamIf.sv */
// Tagged burst stream from the ingress stage to the egress stage.
// A burst moves on a clock edge where valid and ready are both high.
`timescale 1ns/100ps

interface burstStreamIf;
    import cipherPkg::*;

    burstT data;
    maskT  mask;
    // First burst of a bucket
    logic  header;
    logic  valid;
    logic  ready;

    modport source (
        output data,
        output mask,
        output header,
        output valid,
        input  ready
    );

    modport sink (
        input  data,
        input  mask,
        input  header,
        input  valid,
        output ready
    );

endinterface

/* verilog/cipherPkg.sv */
// Burst widths and keystream constants for the counter-mode layer.
// Import where bursts, masks, IVs or keystream lanes are handled.

package cipherPkg;

    // --------------------------------------------------
    // Burst fields
    // --------------------------------------------------
    localparam int DataWidth = 64;
    localparam int MaskWidth = DataWidth / 8;
    localparam int IvWidth   = 16;

    // Keystream is built from independent lanes
    localparam int LaneWidth = 32;
    localparam int Lanes     = DataWidth / LaneWidth;

    // --------------------------------------------------
    // Mixing pipeline
    // --------------------------------------------------
    localparam logic [LaneWidth-1:0] CipherKey = 32'h5A3C_96E1;
    localparam int MixStages = 3;
    localparam int MixRotate = 7;

    // Data, IV and result FIFOs
    localparam int FifoDepth = 4;

    typedef logic [DataWidth-1:0] burstT;
    typedef logic [MaskWidth-1:0] maskT;
    typedef logic [IvWidth-1:0]   ivT;
    typedef logic [LaneWidth-1:0] laneT;

endpackage

/* verilog/keystreamGen.sv */
// Keystream generator. Turns each bucket IV into one keystream word per
// burst through a keyed mixing pipeline and buffers the results in order.
`timescale 1ns/100ps

module keystreamGen (
    input  logic              Clock,
    input  logic              reset,
    input  cipherPkg::ivT     iv,
    input  logic              ivValid,
    output logic              ivReady,
    output cipherPkg::burstT  keystream,
    output logic              keyValid,
    input  logic              keyTaken
);
    import cipherPkg::*;
    import oramGeometryPkg::*;

    localparam int CreditWidth = $clog2(FifoDepth + 1);

    bucketCountT             burstIdx;
    logic                    start;
    logic [CreditWidth-1:0]  credits;
    laneT                    counterWord [Lanes];
    laneT                    mixReg [MixStages][Lanes];
    logic [MixStages-1:0]    mixValid;
    burstT                   resultIn;

    // One mixing round on a lane
    function automatic laneT mixLane(input laneT word, input int stageNum);
        laneT x;
        x = word ^ CipherKey;
        x = (x << MixRotate) | (x >> (LaneWidth - MixRotate));
        return x + LaneWidth'(stageNum);
    endfunction

    // --------------------------------------------------
    // Burst issue and credits
    // --------------------------------------------------

    // Credits cover bursts in flight plus words waiting in the buffer
    assign start   = ivValid & (credits != '0);
    assign ivReady = start & (burstIdx == bucketCountT'(BucketBursts - 1));

    always_ff @(posedge Clock) begin
        if (reset) begin
            burstIdx <= '0;
            credits  <= CreditWidth'(FifoDepth);
        end else begin
            if (start) begin
                burstIdx <= ivReady ? '0 : burstIdx + 1'b1;
            end
            if (start && !keyTaken) begin
                credits <= credits - 1'b1;
            end else if (keyTaken && !start) begin
                credits <= credits + 1'b1;
            end
        end
    end

    always_comb begin
        for (int l = 0; l < Lanes; l++) begin
            counterWord[l] = LaneWidth'(iv) + LaneWidth'(burstIdx) * LaneWidth'(Lanes)
                             + LaneWidth'(l);
        end
    end

    // --------------------------------------------------
    // Mixing pipeline
    // --------------------------------------------------
    always_ff @(posedge Clock) begin
        if (reset) begin
            mixValid <= '0;
        end else begin
            mixValid <= {mixValid[MixStages-2:0], start};
        end
    end

    always_ff @(posedge Clock) begin
        for (int l = 0; l < Lanes; l++) begin
            mixReg[0][l] <= mixLane(counterWord[l], 1);
            for (int s = 1; s < MixStages; s++) begin
                mixReg[s][l] <= mixLane(mixReg[s-1][l], s + 1);
            end
        end
    end

    always_comb begin
        for (int l = 0; l < Lanes; l++) begin
            resultIn[l*LaneWidth +: LaneWidth] = mixReg[MixStages-1][l];
        end
    end

    // Space is guaranteed by the credits
    syncFifo #(.Width(DataWidth), .Depth(FifoDepth)) resultFifo (
        .Clock(Clock), .reset(reset),
        .inData(resultIn), .inValid(mixValid[MixStages-1]), .inReady(),
        .outData(keystream), .outValid(keyValid), .outReady(keyTaken)
    );

endmodule

/* verilog/oramGeometryPkg.sv */
// Path ORAM geometry shared by the encryption layer.
// Import where bucket or path positions and the path direction are tracked.

package oramGeometryPkg;

    // --------------------------------------------------
    // Bucket and path sizes
    // --------------------------------------------------
    localparam int BucketBursts = 4;
    localparam int PathBuckets  = 3;
    localparam int PathBursts   = BucketBursts * PathBuckets;

    // --------------------------------------------------
    // Position counters
    // --------------------------------------------------

    // Burst index within one bucket
    typedef logic [1:0] bucketCountT;

    // Burst index within one path
    typedef logic [3:0] pathCountT;

    // Direction of the path currently being moved
    typedef enum logic {
        PathRead,
        PathWrite
    } pathDirT;

endpackage

/* verilog/pathCrypt.sv */
// Counter-mode encryption layer between a Path ORAM backend and DRAM.
// Decrypts read paths toward the backend and encrypts write paths to memory.
`timescale 1ns/100ps

module pathCrypt (
    input  logic              Clock,
    input  logic              reset,
    input  logic              dramInitDone,

    // Memory side
    input  cipherPkg::burstT  migIn,
    input  logic              migInValid,
    output cipherPkg::burstT  migOut,
    output cipherPkg::maskT   migOutMask,
    output logic              migOutValid,
    input  logic              migOutReady,

    // Backend side
    output cipherPkg::burstT  backendRData,
    output logic              backendRValid,
    input  logic              backendRReady,
    input  cipherPkg::burstT  backendWData,
    input  cipherPkg::maskT   backendWMask,
    input  logic              backendWValid,
    output logic              backendWReady
);
    import cipherPkg::*;

    ivT     iv;
    logic   ivValid;
    logic   ivReady;
    burstT  keystream;
    logic   keyValid;
    logic   keyTaken;

    burstStreamIf burstBus ();

    // --------------------------------------------------
    // Stages
    // --------------------------------------------------
    bucketIngress ingress (
        .Clock(Clock),
        .reset(reset),
        .dramInitDone(dramInitDone),
        .migIn(migIn),
        .migInValid(migInValid),
        .backendWData(backendWData),
        .backendWMask(backendWMask),
        .backendWValid(backendWValid),
        .backendWReady(backendWReady),
        .iv(iv),
        .ivValid(ivValid),
        .ivReady(ivReady),
        .burstOut(burstBus.source)
    );

    keystreamGen keyGen (
        .Clock(Clock),
        .reset(reset),
        .iv(iv),
        .ivValid(ivValid),
        .ivReady(ivReady),
        .keystream(keystream),
        .keyValid(keyValid),
        .keyTaken(keyTaken)
    );

    bucketEgress egress (
        .Clock(Clock),
        .reset(reset),
        .dramInitDone(dramInitDone),
        .burstIn(burstBus.sink),
        .keystream(keystream),
        .keyValid(keyValid),
        .keyTaken(keyTaken),
        .migOut(migOut),
        .migOutMask(migOutMask),
        .migOutValid(migOutValid),
        .migOutReady(migOutReady),
        .backendRData(backendRData),
        .backendRValid(backendRValid),
        .backendRReady(backendRReady)
    );

endmodule

/* verilog/syncFifo.sv */
// Synchronous FIFO with valid/ready on both sides, any depth.
// Push and pop may happen in the same cycle.
`timescale 1ns/100ps

module syncFifo #(
    parameter int Width = 8,
    parameter int Depth = 4
) (
    input  logic             Clock,
    input  logic             reset,
    input  logic [Width-1:0] inData,
    input  logic             inValid,
    output logic             inReady,
    output logic [Width-1:0] outData,
    output logic             outValid,
    input  logic             outReady
);

    localparam int PtrWidth   = (Depth > 1) ? $clog2(Depth) : 1;
    localparam int CountWidth = $clog2(Depth + 1);

    logic [Width-1:0]      storage [Depth];
    logic [PtrWidth-1:0]   wrPtr;
    logic [PtrWidth-1:0]   rdPtr;
    logic [CountWidth-1:0] count;
    logic                  push;
    logic                  pop;

    assign inReady  = (count != CountWidth'(Depth));
    assign outValid = (count != '0);
    assign outData  = storage[rdPtr];

    assign push = inValid & inReady;
    assign pop  = outValid & outReady;

    always_ff @(posedge Clock) begin
        if (push) begin
            storage[wrPtr] <= inData;
        end
    end

    // Pointers wrap explicitly so non power of two depths work
    always_ff @(posedge Clock) begin
        if (reset) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= (wrPtr == PtrWidth'(Depth - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= (rdPtr == PtrWidth'(Depth - 1)) ? '0 : rdPtr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule
